// ==== source/fm_timer_pkg.sv ====
// **********************************************************************
// FM timer package
// Counter widths, host register map and control/status bit positions
// shared by the timer block of the FM sound chip
// **********************************************************************

package fm_timer_pkg;

	// Counter widths of the two timers
	localparam int cnt_width_a = 10; // NA is 10 bits
	localparam int cnt_width_b = 8;  // NB is 8 bits

	// Host register addresses of the timer block
	typedef enum logic [7:0] {
		reg_na_hi = 8'h24, // NA bits 9:2
		reg_na_lo = 8'h25, // NA bits 1:0 in din[1:0]
		reg_nb    = 8'h26, // NB, full byte
		reg_ctrl  = 8'h27  // Run, irq enable and flag clear bits
	} reg_addr_e;

	// Bit positions inside the control byte at reg_ctrl
	localparam int ctl_load_a = 0; // Run timer A
	localparam int ctl_load_b = 1; // Run timer B
	localparam int ctl_en_a   = 2; // Irq enable for flag A
	localparam int ctl_en_b   = 3; // Irq enable for flag B
	localparam int ctl_clr_a  = 4; // Clear strobe for flag A
	localparam int ctl_clr_b  = 5; // Clear strobe for flag B

	// Bits 7:6 of the control byte are unused here
	// (CSM mode and the upper channel bits live elsewhere in the chip)

	// Bit positions inside the status byte
	localparam int stat_flag_a = 0; // Timer A overflow flag
	localparam int stat_flag_b = 1; // Timer B overflow flag

	// Remaining status bits read back as zero,
	// the busy flag is not part of this block

endpackage

// ==== source/timer_regs.sv ====
// **********************************************************************
// Timer register decoder
// Turns host byte writes into timer start values, run bits, irq
// enables and single-cycle flag clear strobes
// **********************************************************************

`timescale 1ns/1ns

module timer_regs (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr,       // Write strobe, one cycle per byte
	input  logic [7:0] addr,
	input  logic [7:0] din,
	output logic [9:0] value_a,  // NA start value
	output logic [7:0] value_b,  // NB start value
	output logic       run_a,
	output logic       run_b,
	output logic       irq_en_a,
	output logic       irq_en_b,
	output logic       clr_a,    // One cycle after a ctrl write
	output logic       clr_b
);

	logic [fm_timer_pkg::cnt_width_a-1:0] na;  // NA assembled from two writes
	logic [fm_timer_pkg::cnt_width_b-1:0] nb;
	logic                                 ctrl_wr; // Write hits the control byte

	assign ctrl_wr = wr && (addr == fm_timer_pkg::reg_ctrl);

	// Start values written by the host
	always_ff @(posedge clk) begin
		if (rst) begin
			na <= '0;
			nb <= '0;
		end else if (wr) begin
			case (fm_timer_pkg::reg_addr_e'(addr))
				fm_timer_pkg::reg_na_hi: na[9:2] <= din;     // Upper byte of NA
				fm_timer_pkg::reg_na_lo: na[1:0] <= din[1:0]; // Low two bits
				fm_timer_pkg::reg_nb:    nb      <= din;
				default: ;                                    // Other addresses ignored
			endcase
		end
	end

	// Held control levels from the control byte
	always_ff @(posedge clk) begin
		if (rst) begin
			run_a    <= 1'b0;
			run_b    <= 1'b0;
			irq_en_a <= 1'b0;
			irq_en_b <= 1'b0;
		end else if (ctrl_wr) begin
			run_a    <= din[fm_timer_pkg::ctl_load_a];
			run_b    <= din[fm_timer_pkg::ctl_load_b];
			irq_en_a <= din[fm_timer_pkg::ctl_en_a];
			irq_en_b <= din[fm_timer_pkg::ctl_en_b];
		end
	end

	// Clear bits become strobes and are not stored
	always_ff @(posedge clk) begin
		if (rst) begin
			clr_a <= 1'b0;
			clr_b <= 1'b0;
		end else begin
			clr_a <= ctrl_wr && din[fm_timer_pkg::ctl_clr_a]; // High one cycle
			clr_b <= ctrl_wr && din[fm_timer_pkg::ctl_clr_b];
		end
	end

	assign value_a = na;
	assign value_b = nb;

	// A strobe only repeats when the host writes the control byte again
	property p_clr_single(logic clr);
		@(posedge clk) disable iff (rst)
			clr && !ctrl_wr |=> !clr;
	endproperty

	a_clr_a_single: assert property (p_clr_single(clr_a))
		else $error("clr_a held high without a second ctrl write");
	a_clr_b_single: assert property (p_clr_single(clr_b))
		else $error("clr_b held high without a second ctrl write");

endmodule

// ==== source/prescaled_timer.sv ====
// **********************************************************************
// Prescaled timer
// Divides clk_en by a fixed prescale and counts up from a start
// value, reloading it and pulsing overflow when the count wraps
// **********************************************************************

`timescale 1ns/1ns

module prescaled_timer #(
	parameter int counter_width = 10,
	parameter int prescale      = 24
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     clk_en,      // Chip clock enable
	input  logic [counter_width-1:0] start_value,
	input  logic                     run,         // Timer runs while high
	output logic                     overflow     // One clock on wrap
);

	localparam int pre_width = (prescale > 1) ? $clog2(prescale) : 1;
	localparam logic [pre_width-1:0] pre_last = pre_width'(prescale - 1);

	logic [pre_width-1:0]     pre;  // Prescale counter
	logic [counter_width-1:0] cnt;  // Main up-counter
	logic                     step; // Prescaler wraps on this enabled cycle

	assign step     = run && clk_en && (pre == pre_last);
	assign overflow = step && (&cnt); // Stepping out of all ones

	always_ff @(posedge clk) begin
		if (rst) begin
			pre <= '0;
			cnt <= '0;
		end else if (!run) begin
			pre <= '0;          // Hold at start while stopped
			cnt <= start_value;
		end else if (clk_en) begin
			if (step) begin
				pre <= '0;
				if (overflow)
					cnt <= start_value; // Reload on wrap
				else
					cnt <= cnt + 1'b1;
			end else begin
				pre <= pre + 1'b1;
			end
		end
	end

	// With a prescale above one the wrap cannot repeat on the next clock
	a_ovf_single: assert property (
		@(posedge clk) disable iff (rst)
			overflow |=> !overflow
	) else $error("overflow high in two consecutive cycles");

endmodule

// ==== source/timer_flags.sv ====
// **********************************************************************
// Timer flags
// Latches the overflow events of both timers, packs them into the
// status byte and forms the active-low interrupt
// **********************************************************************

`timescale 1ns/1ns

module timer_flags (
	input  logic       clk,
	input  logic       rst,
	input  logic       ovf_a,    // Overflow pulse of timer A
	input  logic       ovf_b,
	input  logic       clr_a,    // Clear strobes from the register block
	input  logic       clr_b,
	input  logic       irq_en_a,
	input  logic       irq_en_b,
	output logic [7:0] status,
	output logic       irq_n     // Low while an enabled flag is set
);

	logic flag_a;
	logic flag_b;

	// Clear takes priority over a set in the same cycle
	always_ff @(posedge clk) begin
		if (rst || clr_a)
			flag_a <= 1'b0;
		else if (ovf_a)
			flag_a <= 1'b1; // Stays set until cleared
	end

	always_ff @(posedge clk) begin
		if (rst || clr_b)
			flag_b <= 1'b0;
		else if (ovf_b)
			flag_b <= 1'b1;
	end

	// Status byte with unused bits at zero
	always_comb begin
		status = 8'h00;
		status[fm_timer_pkg::stat_flag_a] = flag_a;
		status[fm_timer_pkg::stat_flag_b] = flag_b;
	end

	assign irq_n = ~((flag_a & irq_en_a) | (flag_b & irq_en_b)); // Masked irq

	// Flag reads low right after the host clears it
	a_clr_a_wins: assert property (
		@(posedge clk) disable iff (rst)
			clr_a |=> !flag_a
	) else $error("flag A still set after clear strobe");

	a_clr_b_wins: assert property (
		@(posedge clk) disable iff (rst)
			clr_b |=> !flag_b
	) else $error("flag B still set after clear strobe");

endmodule

// ==== source/fm_timers.sv ====
// **********************************************************************
// FM timers top level
// Host register block, timers A and B and the flag/irq logic of
// the FM chip timer section
// **********************************************************************

`timescale 1ns/1ns

module fm_timers #(
	parameter int prescale_a = 24,  // Timer A divider
	parameter int prescale_b = 384  // Timer B divider
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_en,     // Chip clock enable from outside
	input  logic       wr,
	input  logic [7:0] addr,
	input  logic [7:0] din,
	output logic [7:0] status,
	output logic       overflow_a, // To key-on logic
	output logic       irq_n
);

	logic [fm_timer_pkg::cnt_width_a-1:0] value_a;
	logic [fm_timer_pkg::cnt_width_b-1:0] value_b;
	logic                                 run_a;
	logic                                 run_b;
	logic                                 irq_en_a;
	logic                                 irq_en_b;
	logic                                 clr_a;
	logic                                 clr_b;
	logic                                 overflow_b; // Only feeds the flag

	timer_regs regs (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.addr     (addr),
		.din      (din),
		.value_a  (value_a),
		.value_b  (value_b),
		.run_a    (run_a),
		.run_b    (run_b),
		.irq_en_a (irq_en_a),
		.irq_en_b (irq_en_b),
		.clr_a    (clr_a),
		.clr_b    (clr_b)
	);

	prescaled_timer #(
		.counter_width (fm_timer_pkg::cnt_width_a),
		.prescale      (prescale_a)
	) timer_a (
		.clk         (clk),
		.rst         (rst),
		.clk_en      (clk_en),
		.start_value (value_a),
		.run         (run_a),
		.overflow    (overflow_a)
	);

	prescaled_timer #(
		.counter_width (fm_timer_pkg::cnt_width_b),
		.prescale      (prescale_b)
	) timer_b (
		.clk         (clk),
		.rst         (rst),
		.clk_en      (clk_en),
		.start_value (value_b),
		.run         (run_b),
		.overflow    (overflow_b)
	);

	timer_flags flags (
		.clk      (clk),
		.rst      (rst),
		.ovf_a    (overflow_a),
		.ovf_b    (overflow_b),
		.clr_a    (clr_a),
		.clr_b    (clr_b),
		.irq_en_a (irq_en_a),
		.irq_en_b (irq_en_b),
		.status   (status),
		.irq_n    (irq_n)
	);

endmodule

// ==== tb/fm_timers_ref.svh ====
// **********************************************************************
// FM timers reference model
// Expected overflow period, status byte and interrupt level
// **********************************************************************

`ifndef FM_TIMERS_REF_SVH
`define FM_TIMERS_REF_SVH

// Clock cycles from one overflow to the next
function automatic int expected_period(
	input int prescale,
	input int width,
	input int start,
	input int ce_ratio
);
	int steps;
	steps = (1 << width) - start; // Counts from start up through all ones
	return prescale * steps * ce_ratio;
endfunction

// Status byte with both flags at their register positions
function automatic logic [7:0] expected_status(
	input logic flag_a,
	input logic flag_b
);
	logic [7:0] s;
	s = 8'h00;                              // Unused bits read zero
	s[fm_timer_pkg::stat_flag_a] = flag_a;
	s[fm_timer_pkg::stat_flag_b] = flag_b;
	return s;
endfunction

// Active-low interrupt from flags masked by their enables
function automatic logic expected_irq_n(
	input logic flag_a,
	input logic flag_b,
	input logic en_a,
	input logic en_b
);
	return !((flag_a && en_a) || (flag_b && en_b));
endfunction

`endif

// ==== tb/fm_timers_tb.sv ====
// **********************************************************************
// FM timers testbench
// Register writes, timer periods, flag set/clear and irq masking,
// with a cycle-by-cycle model of the status byte and irq_n
// **********************************************************************

`timescale 1ns/1ns

module fm_timers_tb;

	`include "fm_timers_ref.svh"

	localparam int prescale_a = 24;  // Default dividers of the DUT
	localparam int prescale_b = 384;

	logic       clk;
	logic       rst;
	logic       clk_en;
	logic       wr;
	logic [7:0] addr;
	logic [7:0] din;
	logic [7:0] status;
	logic       overflow_a;
	logic       irq_n;

	int          cyc = 0;             // Posedge count read at negedge
	int          errors = 0;
	int          cycle_limit = 100000; // Replaced once periods are known
	int          ce_ratio = 1;        // Clock cycles per clk_en pulse
	integer      seed;
	logic [31:0] rnd;
	logic [9:0]  na;
	logic [7:0]  nb;
	int          pa;
	int          pb;
	int          last_wr_cyc;          // Edge on which the DUT took the last write

	logic        ctrl_pending = 1'b0; // Control write not yet seen by the model
	int          ctrl_edge;
	logic [7:0]  ctrl_data;

	logic        m_flag_a;
	logic        m_flag_b;
	logic        m_en_a;
	logic        m_en_b;
	logic        m_clr_a;             // Events of the previous cycle
	logic        m_clr_b;
	logic        m_ovf_a;
	logic        m_ovf_b;
	logic        m_run_b;
	logic        b_wait_first;        // Timer B waits for its first enabled cycle
	int          b_next;              // Predicted timer B overflow cycle
	int          b_pred_first;

	fm_timers fm_timers_inst (
		.clk        (clk),
		.rst        (rst),
		.clk_en     (clk_en),
		.wr         (wr),
		.addr       (addr),
		.din        (din),
		.status     (status),
		.overflow_a (overflow_a),
		.irq_n      (irq_n)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	always @(posedge clk) cyc <= cyc + 1;

	// Chip clock enable at full or half rate
	always @(posedge clk) begin
		if (ce_ratio == 2)
			clk_en <= ~clk_en;
		else
			clk_en <= 1'b1;
	end

	always @(posedge clk) begin
		if (cyc >= cycle_limit) begin
			$display("Run stopped at cycle %0d, limit reached", cyc);
			$display("Errors: %0d", errors);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic logic [7:0] make_ctrl(
		input logic run_a,
		input logic run_b,
		input logic en_a,
		input logic en_b,
		input logic clr_a,
		input logic clr_b
	);
		logic [7:0] c;
		c = 8'h00;
		c[fm_timer_pkg::ctl_load_a] = run_a;
		c[fm_timer_pkg::ctl_load_b] = run_b;
		c[fm_timer_pkg::ctl_en_a]   = en_a;
		c[fm_timer_pkg::ctl_en_b]   = en_b;
		c[fm_timer_pkg::ctl_clr_a]  = clr_a;
		c[fm_timer_pkg::ctl_clr_b]  = clr_b;
		return c;
	endfunction

	// One-cycle write taken by the DUT on the second edge
	task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
		@(posedge clk);
		wr   <= 1'b1;
		addr <= a;
		din  <= d;
		@(posedge clk);
		wr <= 1'b0;
		last_wr_cyc = cyc + 1;
		if (a == fm_timer_pkg::reg_ctrl) begin
			ctrl_edge    = cyc + 1;
			ctrl_data    = d;
			ctrl_pending = 1'b1;
		end
	endtask

	task automatic wait_overflow(input int max_cycles, output int at_cycle);
		int n;
		at_cycle = -1;
		n = 0;
		while (at_cycle < 0 && n < max_cycles) begin
			@(negedge clk);
			n++;
			if (overflow_a)
				at_cycle = cyc;
		end
		if (at_cycle < 0) begin
			errors++;
			$display("No overflow_a pulse within %0d cycles", max_cycles);
		end
	endtask

	// Status and irq_n checked against the model every cycle
	always @(negedge clk) begin : compare
		logic [7:0] exp_status;
		logic       exp_irq_n;
		if (rst) begin
			m_flag_a     = 1'b0;
			m_flag_b     = 1'b0;
			m_en_a       = 1'b0;
			m_en_b       = 1'b0;
			m_clr_a      = 1'b0;
			m_clr_b      = 1'b0;
			m_ovf_a      = 1'b0;
			m_ovf_b      = 1'b0;
			m_run_b      = 1'b0;
			b_wait_first = 1'b0;
		end else begin
			if (m_clr_a)
				m_flag_a = 1'b0; // Clear beats set
			else if (m_ovf_a)
				m_flag_a = 1'b1;
			if (m_clr_b)
				m_flag_b = 1'b0;
			else if (m_ovf_b)
				m_flag_b = 1'b1;
			m_clr_a = 1'b0;
			m_clr_b = 1'b0;
			if (ctrl_pending && ctrl_edge == cyc) begin
				ctrl_pending = 1'b0;
				m_en_a  = ctrl_data[fm_timer_pkg::ctl_en_a];
				m_en_b  = ctrl_data[fm_timer_pkg::ctl_en_b];
				m_clr_a = ctrl_data[fm_timer_pkg::ctl_clr_a]; // Strobe in this cycle
				m_clr_b = ctrl_data[fm_timer_pkg::ctl_clr_b];
				if (ctrl_data[fm_timer_pkg::ctl_load_b] && !m_run_b)
					b_wait_first = 1'b1;
				m_run_b = ctrl_data[fm_timer_pkg::ctl_load_b];
			end
			m_ovf_b = 1'b0;
			if (m_run_b) begin
				if (b_wait_first && clk_en) begin
					b_wait_first = 1'b0; // Period counts from here
					b_next = cyc + expected_period(prescale_b, fm_timer_pkg::cnt_width_b,
						nb, ce_ratio) - ce_ratio;
					b_pred_first = b_next;
				end
				if (!b_wait_first && cyc == b_next) begin
					m_ovf_b = 1'b1;
					b_next = b_next + expected_period(prescale_b,
						fm_timer_pkg::cnt_width_b, nb, ce_ratio);
				end
			end
			m_ovf_a = overflow_a; // Timer A seen directly
			exp_status = expected_status(m_flag_a, m_flag_b);
			exp_irq_n  = expected_irq_n(m_flag_a, m_flag_b, m_en_a, m_en_b);
			if (status !== exp_status) begin
				errors++;
				$display("FAILED status expected %h got %h", exp_status, status);
			end
			if (irq_n !== exp_irq_n) begin
				errors++;
				$display("FAILED irq_n expected %h got %h", exp_irq_n, irq_n);
			end
		end
	end

	initial begin : stimulus
		int w;
		int t;
		int prev;
		int rise;
		int n;
		rst    = 1'b1;
		clk_en = 1'b1;
		wr     = 1'b0;
		addr   = 8'h00;
		din    = 8'h00;
		seed = 32'haf3f;
		rnd  = $random(seed);
		na   = 10'd1016 + rnd[2:0]; // Short periods
		rnd  = $random(seed);
		nb   = 8'd252 + rnd[1:0];
		pa   = expected_period(prescale_a, fm_timer_pkg::cnt_width_a, na, 1);
		pb   = expected_period(prescale_b, fm_timer_pkg::cnt_width_b, nb, 2);
		cycle_limit = 3 * (7 * pa + pb) + 2000;

		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (status !== 8'h00) begin
			errors++;
			$display("FAILED status expected %h got %h", 8'h00, status);
		end
		if (irq_n !== 1'b1) begin
			errors++;
			$display("FAILED irq_n expected %h got %h", 1'b1, irq_n);
		end
		if (overflow_a !== 1'b0) begin
			errors++;
			$display("FAILED overflow_a expected %h got %h", 1'b0, overflow_a);
		end

		// Timer A at full clk_en rate
		write_reg(fm_timer_pkg::reg_na_hi, na[9:2]);
		write_reg(fm_timer_pkg::reg_na_lo, {6'b0, na[1:0]});
		write_reg(fm_timer_pkg::reg_ctrl, make_ctrl(1, 0, 0, 0, 0, 0));
		w = last_wr_cyc;
		wait_overflow(pa + 8, t);
		if (t >= 0 && t != w + pa - 1) begin
			errors++;
			$display("FAILED overflow_a first cycle expected %h got %h", w + pa - 1, t);
		end
		repeat (3) begin
			@(negedge clk);
			if (overflow_a !== 1'b0) begin
				errors++;
				$display("FAILED overflow_a width expected %h got %h", 1'b0, overflow_a);
			end
			prev = t;
			wait_overflow(pa + 8, t);
			if (t >= 0 && t - prev != pa) begin
				errors++;
				$display("FAILED overflow_a gap expected %h got %h", pa, t - prev);
			end
		end
		@(negedge clk);
		if (overflow_a !== 1'b0) begin
			errors++;
			$display("FAILED overflow_a width expected %h got %h", 1'b0, overflow_a);
		end
		write_reg(fm_timer_pkg::reg_ctrl, make_ctrl(0, 0, 0, 0, 0, 0));

		// Timer B with clk_en every second cycle
		@(posedge clk);
		ce_ratio <= 2;
		write_reg(fm_timer_pkg::reg_nb, nb);
		write_reg(fm_timer_pkg::reg_ctrl, make_ctrl(0, 1, 0, 0, 0, 0));
		rise = -1;
		n = 0;
		while (rise < 0 && n < pb + 16) begin
			@(negedge clk);
			n++;
			if (status[fm_timer_pkg::stat_flag_b])
				rise = cyc;
		end
		if (rise < 0) begin
			errors++;
			$display("Status flag B never rose after timer B was started");
		end else if (rise != b_pred_first + 1) begin
			errors++;
			$display("FAILED status[1] rise cycle expected %h got %h", b_pred_first + 1, rise);
		end
		write_reg(fm_timer_pkg::reg_ctrl, make_ctrl(0, 0, 0, 0, 0, 0));
		@(posedge clk);
		ce_ratio <= 1;

		// Both flags set, irq masking
		@(negedge clk);
		if (irq_n !== 1'b1) begin
			errors++;
			$display("FAILED irq_n expected %h got %h", 1'b1, irq_n);
		end
		write_reg(fm_timer_pkg::reg_ctrl, make_ctrl(0, 0, 1, 0, 0, 0));
		@(negedge clk);
		if (irq_n !== expected_irq_n(1'b1, 1'b1, 1'b1, 1'b0)) begin
			errors++;
			$display("FAILED irq_n expected %h got %h", 1'b0, irq_n);
		end
		write_reg(fm_timer_pkg::reg_ctrl, make_ctrl(0, 0, 0, 1, 0, 0));
		@(negedge clk);
		if (irq_n !== expected_irq_n(1'b1, 1'b1, 1'b0, 1'b1)) begin
			errors++;
			$display("FAILED irq_n expected %h got %h", 1'b0, irq_n);
		end

		// Clear one flag at a time
		write_reg(fm_timer_pkg::reg_ctrl, make_ctrl(0, 0, 0, 1, 1, 0));
		repeat (2) @(negedge clk);
		if (status !== expected_status(1'b0, 1'b1)) begin
			errors++;
			$display("FAILED status expected %h got %h", expected_status(1'b0, 1'b1), status);
		end
		write_reg(fm_timer_pkg::reg_ctrl, make_ctrl(0, 0, 0, 0, 0, 1));
		repeat (2) @(negedge clk);
		if (status !== expected_status(1'b0, 1'b0)) begin
			errors++;
			$display("FAILED status expected %h got %h", expected_status(1'b0, 1'b0), status);
		end

		// Stopped timer A stays silent
		write_reg(fm_timer_pkg::reg_ctrl, make_ctrl(1, 0, 0, 0, 0, 0));
		wait_overflow(pa + 8, t);
		write_reg(fm_timer_pkg::reg_ctrl, make_ctrl(0, 0, 0, 0, 0, 0));
		repeat (2 * pa) begin
			@(negedge clk);
			if (overflow_a !== 1'b0) begin
				errors++;
				$display("FAILED overflow_a stopped expected %h got %h", 1'b0, overflow_a);
			end
		end

		repeat (4) @(negedge clk);
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+tb
source/fm_timer_pkg.sv
source/timer_regs.sv
source/prescaled_timer.sv
source/timer_flags.sv
source/fm_timers.sv
tb/fm_timers_tb.sv

// ==== Bender.yml ====
package:
  name: fm_timers

sources:
  - files:
      - source/fm_timer_pkg.sv
      - source/timer_regs.sv
      - source/prescaled_timer.sv
      - source/timer_flags.sv
      - source/fm_timers.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/fm_timers_tb.sv
